//--- hdl/dcache_pkg.sv
package dcache_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [63:0]  beat_t;
    typedef logic [255:0] line_t;    // beat 0 in bits 63:0
    typedef logic [3:0]   axi_id_t;

    localparam int unsigned BEATS_PER_LINE = 4;
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

    localparam logic [7:0] AXI_LEN        = 8'd3;    // four beats
    localparam logic [2:0] AXI_SIZE       = 3'd3;    // 8 bytes per beat
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam axi_id_t    AXI_ID         = 4'd1;

    typedef enum logic {
        OP_REFILL,
        OP_WRITEBACK
    } line_op_e;

    typedef struct packed {
        line_op_e op;
        addr_t    addr;    // line aligned
        line_t    data;    // only meaningful for writebacks
    } line_req_t;

    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        beat_t      data;
        logic [7:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t    id;
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        axi_id_t    id;
        beat_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    // one accepted R beat, tagged with the line it belongs to
    typedef struct packed {
        addr_t addr;
        beat_t data;
        logic  last;
    } read_beat_t;

    typedef struct packed {
        addr_t addr;
        line_t data;
    } refill_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

endpackage

//--- hdl/miss_queue.sv
`timescale 1ns/100ps

module miss_queue #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  push_i,
    input  dcache_pkg::line_req_t push_req_i,
    output logic                  full_o,
    input  logic                  pop_i,
    output logic                  head_valid_o,
    output dcache_pkg::line_req_t head_req_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    dcache_pkg::line_req_t entries [QUEUE_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_push;
    logic                  do_pop;

    // wrap explicitly so non power of two depths also work
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o       = count == CNT_W'(QUEUE_DEPTH);
    assign head_valid_o = count != '0;
    assign head_req_o   = entries[rd_ptr];
    assign do_push      = push_i && !full_o;
    assign do_pop       = pop_i && head_valid_o;

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= push_req_i;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop) rd_ptr <= ptr_next(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or both at once
            endcase
        end
    end

endmodule

//--- hdl/axi_line_master.sv
`timescale 1ns/100ps

module axi_line_master (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   head_valid_i,
    input  dcache_pkg::line_req_t  head_req_i,
    output logic                   pop_o,
    output dcache_pkg::axi_aw_t    aw_o,
    output logic                   aw_valid_o,
    input  logic                   aw_ready_i,
    output dcache_pkg::axi_w_t     w_o,
    output logic                   w_valid_o,
    input  logic                   w_ready_i,
    input  dcache_pkg::axi_b_t     b_i,
    input  logic                   b_valid_i,
    output logic                   b_ready_o,
    output dcache_pkg::axi_ar_t    ar_o,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    input  dcache_pkg::axi_r_t     r_i,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    output logic                   rd_beat_valid_o,
    output dcache_pkg::read_beat_t rd_beat_o,
    output logic                   wb_done_o
);

    dcache_pkg::wr_state_e wr_state;
    dcache_pkg::wr_state_e wr_state_nxt;
    dcache_pkg::rd_state_e rd_state;
    dcache_pkg::rd_state_e rd_state_nxt;
    dcache_pkg::addr_t     wr_addr;
    dcache_pkg::line_t     wr_line;
    dcache_pkg::beat_idx_t wr_cnt;
    dcache_pkg::addr_t     rd_addr;
    logic                  head_is_wb;
    logic                  same_line;
    logic                  take_wb;
    logic                  take_rd;
    logic                  w_fire;
    logic                  b_fire;
    logic                  r_fire;
    logic                  w_last;

    // dispatch, strictly in queue order
    assign head_is_wb = head_req_i.op == dcache_pkg::OP_WRITEBACK;
    // writeback to the same line still waiting for B
    assign same_line  = (wr_state != dcache_pkg::WR_IDLE) && (wr_addr == head_req_i.addr);
    assign take_wb    = head_valid_i && head_is_wb && (wr_state == dcache_pkg::WR_IDLE);
    assign take_rd    = head_valid_i && !head_is_wb && (rd_state == dcache_pkg::RD_IDLE)
                        && !same_line;
    assign pop_o      = take_wb || take_rd;

    assign w_fire = w_valid_o && w_ready_i;
    assign b_fire = b_valid_i && b_ready_o;
    assign r_fire = r_valid_i && r_ready_o;
    assign w_last = wr_cnt == dcache_pkg::beat_idx_t'(dcache_pkg::BEATS_PER_LINE - 1);

    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            dcache_pkg::WR_IDLE: if (take_wb) wr_state_nxt = dcache_pkg::WR_ADDR;
            dcache_pkg::WR_ADDR: if (aw_ready_i) wr_state_nxt = dcache_pkg::WR_DATA;
            dcache_pkg::WR_DATA: if (w_fire && w_last) wr_state_nxt = dcache_pkg::WR_RESP;
            dcache_pkg::WR_RESP: if (b_valid_i) wr_state_nxt = dcache_pkg::WR_IDLE;
            default:             wr_state_nxt = dcache_pkg::WR_IDLE;
        endcase
    end

    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            dcache_pkg::RD_IDLE: if (take_rd) rd_state_nxt = dcache_pkg::RD_ADDR;
            dcache_pkg::RD_ADDR: if (ar_ready_i) rd_state_nxt = dcache_pkg::RD_DATA;
            dcache_pkg::RD_DATA: if (r_fire && r_i.last) rd_state_nxt = dcache_pkg::RD_IDLE;
            default:             rd_state_nxt = dcache_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state  <= dcache_pkg::WR_IDLE;
            rd_state  <= dcache_pkg::RD_IDLE;
            wr_cnt    <= '0;
            wb_done_o <= 1'b0;
        end else begin
            wr_state  <= wr_state_nxt;
            rd_state  <= rd_state_nxt;
            wb_done_o <= b_fire;    // one cycle after B
            if (take_wb) begin
                wr_cnt <= '0;
            end else if (w_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // latched only from idle, so payload holds while valid is up
    always_ff @(posedge clock) begin
        if (take_wb) begin
            wr_addr <= head_req_i.addr;
            wr_line <= head_req_i.data;
        end
        if (take_rd) rd_addr <= head_req_i.addr;
    end

    assign aw_valid_o = wr_state == dcache_pkg::WR_ADDR;
    assign w_valid_o  = wr_state == dcache_pkg::WR_DATA;
    assign b_ready_o  = wr_state == dcache_pkg::WR_RESP;
    assign ar_valid_o = rd_state == dcache_pkg::RD_ADDR;
    assign r_ready_o  = rd_state == dcache_pkg::RD_DATA;

    assign aw_o = '{id:    dcache_pkg::AXI_ID,
                    addr:  wr_addr,
                    len:   dcache_pkg::AXI_LEN,
                    size:  dcache_pkg::AXI_SIZE,
                    burst: dcache_pkg::AXI_BURST_INCR};
    assign ar_o = '{id:    dcache_pkg::AXI_ID,
                    addr:  rd_addr,
                    len:   dcache_pkg::AXI_LEN,
                    size:  dcache_pkg::AXI_SIZE,
                    burst: dcache_pkg::AXI_BURST_INCR};

    // beat slice picked by the counter, full strobe always
    assign w_o = '{data: wr_line[{wr_cnt, 6'b0} +: 64],
                   strb: 8'hff,
                   last: w_last};

    // resp and id of R and B are not checked
    assign rd_beat_valid_o = r_fire;
    assign rd_beat_o       = '{addr: rd_addr, data: r_i.data, last: r_i.last};

endmodule

//--- hdl/refill_assembler.sv
`timescale 1ns/100ps

module refill_assembler (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   beat_valid_i,
    input  dcache_pkg::read_beat_t beat_i,
    output logic                   refill_valid_o,
    output dcache_pkg::refill_t    refill_o
);

    dcache_pkg::beat_idx_t cnt;
    dcache_pkg::line_t     line_q;
    dcache_pkg::addr_t     addr_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cnt            <= '0;
            refill_valid_o <= 1'b0;
        end else begin
            refill_valid_o <= beat_valid_i && beat_i.last;
            if (beat_valid_i) begin
                cnt <= beat_i.last ? '0 : cnt + 1'b1;    // realign on every last
            end
        end
    end

    always_ff @(posedge clock) begin
        if (beat_valid_i) begin
            line_q[{cnt, 6'b0} +: 64] <= beat_i.data;
            if (beat_i.last) addr_q <= beat_i.addr;
        end
    end

    // line_q already holds the last beat while the strobe is up
    assign refill_o = '{addr: addr_q, data: line_q};

endmodule

//--- hdl/dcache_axi_top.sv
`timescale 1ns/100ps

module dcache_axi_top #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  dcache_pkg::line_req_t req_i,
    output logic                  refill_valid_o,
    output dcache_pkg::refill_t   refill_o,
    output logic                  wb_done_o,
    output dcache_pkg::axi_aw_t   aw_o,
    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output dcache_pkg::axi_w_t    w_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    input  dcache_pkg::axi_b_t    b_i,
    input  logic                  b_valid_i,
    output logic                  b_ready_o,
    output dcache_pkg::axi_ar_t   ar_o,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    input  dcache_pkg::axi_r_t    r_i,
    input  logic                  r_valid_i,
    output logic                  r_ready_o
);

    logic                   queue_full;
    logic                   head_valid;
    dcache_pkg::line_req_t  head_req;
    logic                   pop;
    logic                   rd_beat_valid;
    dcache_pkg::read_beat_t rd_beat;

    assign req_ready_o = !queue_full;

    miss_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_miss_queue (
        .clock        (clock),
        .reset        (reset),
        .push_i       (req_valid_i && req_ready_o),    // accepted request
        .push_req_i   (req_i),
        .full_o       (queue_full),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_req_o   (head_req)
    );

    axi_line_master u_axi_line_master (
        .clock           (clock),
        .reset           (reset),
        .head_valid_i    (head_valid),
        .head_req_i      (head_req),
        .pop_o           (pop),
        .aw_o            (aw_o),
        .aw_valid_o      (aw_valid_o),
        .aw_ready_i      (aw_ready_i),
        .w_o             (w_o),
        .w_valid_o       (w_valid_o),
        .w_ready_i       (w_ready_i),
        .b_i             (b_i),
        .b_valid_i       (b_valid_i),
        .b_ready_o       (b_ready_o),
        .ar_o            (ar_o),
        .ar_valid_o      (ar_valid_o),
        .ar_ready_i      (ar_ready_i),
        .r_i             (r_i),
        .r_valid_i       (r_valid_i),
        .r_ready_o       (r_ready_o),
        .rd_beat_valid_o (rd_beat_valid),
        .rd_beat_o       (rd_beat),
        .wb_done_o       (wb_done_o)
    );

    refill_assembler u_refill_assembler (
        .clock          (clock),
        .reset          (reset),
        .beat_valid_i   (rd_beat_valid),
        .beat_i         (rd_beat),
        .refill_valid_o (refill_valid_o),
        .refill_o       (refill_o)
    );

endmodule

//--- tests/dcache_assertions.sv
`timescale 1ns/100ps

module dcache_assertions (
    input logic                clock,
    input logic                reset,
    input dcache_pkg::axi_aw_t aw_i,
    input logic                aw_valid_i,
    input logic                aw_ready_i,
    input dcache_pkg::axi_w_t  w_i,
    input logic                w_valid_i,
    input logic                w_ready_i,
    input dcache_pkg::axi_ar_t ar_i,
    input logic                ar_valid_i,
    input logic                ar_ready_i
);

    logic [1:0]  w_beats;    // wraps every four beats
    int unsigned fail_count = 0;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_beats <= '0;
        end else if (w_valid_i && w_ready_i) begin
            w_beats <= w_beats + 2'd1;
        end
    end

    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
        else begin $error("AW valid or payload changed before ready"); fail_count++; end

    w_hold: assert property (@(posedge clock) disable iff (!reset)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
        else begin $error("W valid or payload changed before ready"); fail_count++; end

    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
        else begin $error("AR valid or payload changed before ready"); fail_count++; end

    w_last_fourth: assert property (@(posedge clock) disable iff (!reset)
        w_valid_i |-> w_i.last == (w_beats == 2'd3))
        else begin $error("W last not on the fourth beat"); fail_count++; end

    aw_format: assert property (@(posedge clock) disable iff (!reset)
        aw_valid_i |-> aw_i.len == dcache_pkg::AXI_LEN && aw_i.burst == dcache_pkg::AXI_BURST_INCR)
        else begin $error("AW burst is not a four beat INCR"); fail_count++; end

endmodule

bind axi_line_master dcache_assertions u_assertions (
    .clock      (clock),
    .reset      (reset),
    .aw_i       (aw_o),
    .aw_valid_i (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .w_i        (w_o),
    .w_valid_i  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .ar_i       (ar_o),
    .ar_valid_i (ar_valid_o),
    .ar_ready_i (ar_ready_i)
);

//--- tests/dcache_checker.sv
`timescale 1ns/100ps

module dcache_checker (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid_i,
    input  logic                  req_ready_i,
    input  dcache_pkg::line_req_t req_i,
    input  logic                  refill_valid_i,
    input  dcache_pkg::refill_t   refill_i,
    input  logic                  wb_done_i,
    output int                    errors_o,
    output int                    accepted_o,
    output int                    completed_o,
    output int                    wb_seen_o
);

    dcache_pkg::line_t   ref_mem [dcache_pkg::addr_t];
    dcache_pkg::refill_t exp_q [$];
    dcache_pkg::refill_t exp;
    int                  wb_pending;

    // initial memory content, a function of the whole beat address
    function automatic dcache_pkg::beat_t mem_init_beat(input dcache_pkg::addr_t a);
        return {~a, a ^ 32'h9e37_79b9};
    endfunction

    function automatic dcache_pkg::line_t ref_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        if (ref_mem.exists(a)) return ref_mem[a];
        for (int i = 0; i < dcache_pkg::BEATS_PER_LINE; i++) begin
            l[i*64 +: 64] = mem_init_beat(a + dcache_pkg::addr_t'(8 * i));
        end
        return l;
    endfunction

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            errors_o    = 0;
            accepted_o  = 0;
            completed_o = 0;
            wb_seen_o   = 0;
            wb_pending  = 0;
            exp_q.delete();
        end else begin
            if (req_valid_i && req_ready_i) begin
                accepted_o++;
                if (req_i.op == dcache_pkg::OP_WRITEBACK) begin
                    ref_mem[req_i.addr] = req_i.data;    // acceptance order
                    wb_pending++;
                end else begin
                    exp_q.push_back('{addr: req_i.addr, data: ref_line(req_i.addr)});
                end
            end
            if (refill_valid_i) begin
                completed_o++;
                if (exp_q.size() == 0) begin
                    $display("refill_o returned with no refill outstanding");
                    errors_o++;
                end else begin
                    exp = exp_q.pop_front();
                    if (refill_i.addr !== exp.addr) begin
                        $display("Mismatch refill_o.addr: expected %h, actual %h",
                                 exp.addr, refill_i.addr);
                        errors_o++;
                    end
                    if (refill_i.data !== exp.data) begin
                        $display("Mismatch refill_o.data: expected %h, actual %h",
                                 exp.data, refill_i.data);
                        errors_o++;
                    end
                end
            end
            if (wb_done_i) begin
                completed_o++;
                wb_seen_o++;
                if (wb_pending == 0) begin
                    $display("wb_done_o pulsed with no writeback outstanding");
                    errors_o++;
                end else begin
                    wb_pending--;
                end
            end
        end
    end

endmodule

//--- tests/tb_dcache.sv
`timescale 1ns/100ps

module tb_dcache;

    localparam int QUEUE_DEPTH = 2;
    localparam int TOTAL_REQS  = 1 + 2 + 6 + (QUEUE_DEPTH + 2) + 40;
    localparam dcache_pkg::addr_t LINE_BASE = 32'h0000_4000;

    logic clock;
    logic reset;
    logic req_valid;
    logic req_ready;
    dcache_pkg::line_req_t req;
    logic refill_valid;
    dcache_pkg::refill_t refill;
    logic wb_done;
    dcache_pkg::axi_aw_t aw;
    logic aw_valid;
    logic aw_ready;
    dcache_pkg::axi_w_t w;
    logic w_valid;
    logic w_ready;
    dcache_pkg::axi_b_t b;
    logic b_valid;
    logic b_ready;
    dcache_pkg::axi_ar_t ar;
    logic ar_valid;
    logic ar_ready;
    dcache_pkg::axi_r_t r;
    logic r_valid;
    logic r_ready;

    int chk_errors;
    int accepted;
    int completed;
    int wb_seen;
    int tb_errors = 0;
    int passed = 0;
    int failed = 0;
    int ready_pct = 100;
    logic stall = 1'b0;
    int open_refills [8] = '{default: 0};    // refills not yet returned, per line slot
    dcache_pkg::beat_t slave_mem [dcache_pkg::addr_t];
    dcache_pkg::addr_t wb_line;    // line of the writeback on the bus
    logic wb_open = 1'b0;

    dcache_axi_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) dut0 (
        .clock          (clock),
        .reset          (reset),
        .req_valid_i    (req_valid),
        .req_ready_o    (req_ready),
        .req_i          (req),
        .refill_valid_o (refill_valid),
        .refill_o       (refill),
        .wb_done_o      (wb_done),
        .aw_o           (aw),
        .aw_valid_o     (aw_valid),
        .aw_ready_i     (aw_ready),
        .w_o            (w),
        .w_valid_o      (w_valid),
        .w_ready_i      (w_ready),
        .b_i            (b),
        .b_valid_i      (b_valid),
        .b_ready_o      (b_ready),
        .ar_o           (ar),
        .ar_valid_o     (ar_valid),
        .ar_ready_i     (ar_ready),
        .r_i            (r),
        .r_valid_i      (r_valid),
        .r_ready_o      (r_ready)
    );

    dcache_checker chk0 (
        .clock          (clock),
        .reset          (reset),
        .req_valid_i    (req_valid),
        .req_ready_i    (req_ready),
        .req_i          (req),
        .refill_valid_i (refill_valid),
        .refill_i       (refill),
        .wb_done_i      (wb_done),
        .errors_o       (chk_errors),
        .accepted_o     (accepted),
        .completed_o    (completed),
        .wb_seen_o      (wb_seen)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic rnd_bit();
        return !stall && ($urandom_range(99, 0) < ready_pct);
    endfunction

    function automatic dcache_pkg::beat_t mem_read(input dcache_pkg::addr_t a);
        if (slave_mem.exists(a)) return slave_mem[a];
        return chk0.mem_init_beat(a);
    endfunction

    function automatic dcache_pkg::line_t rand_line();
        dcache_pkg::line_t l;
        for (int i = 0; i < 8; i++) l[i*32 +: 32] = $urandom;
        return l;
    endfunction

    function automatic int total_errors();
        return chk_errors + tb_errors + dut0.u_axi_line_master.u_assertions.fail_count;
    endfunction

    // every burst is four beats of 8 bytes, INCR
    task automatic check_burst(input string chan, input logic [7:0] len,
                               input logic [2:0] size, input logic [1:0] burst);
        if (len !== 8'd3 || size !== 3'd3 || burst !== 2'b01) begin
            $display("Mismatch %s len/size/burst: expected 03/3/1, actual %h/%h/%h",
                     chan, len, size, burst);
            tb_errors++;
        end
    endtask

    always @(posedge clock) begin
        if (req_valid && req_ready && req.op == dcache_pkg::OP_REFILL) begin
            open_refills[req.addr[7:5]]++;
        end
        if (refill_valid) open_refills[refill.addr[7:5]]--;
    end

    // no read of a line while a writeback to it still waits for B
    always @(posedge clock) begin
        if (wb_open && ar_valid && ar.addr == wb_line) begin
            $display("refill of line %h started before its writeback got B", ar.addr);
            tb_errors++;
        end
        if (aw_valid) begin
            wb_open = 1'b1;
            wb_line = aw.addr;
        end
        if (b_valid && b_ready) wb_open = 1'b0;
    end

    // AXI write side of the memory slave
    initial begin : write_slave
        dcache_pkg::addr_t wa;
        int i;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b        = '0;
        forever begin
            do begin
                @(negedge clock);
                aw_ready = rnd_bit();
                @(posedge clock);
            end while (!(aw_valid && aw_ready));
            wa = aw.addr;
            check_burst("aw_o", aw.len, aw.size, aw.burst);
            @(negedge clock);
            aw_ready = 1'b0;
            i = 0;
            while (i < dcache_pkg::BEATS_PER_LINE) begin
                w_ready = rnd_bit();
                @(posedge clock);
                if (w_valid && w_ready) begin
                    if (w.strb !== 8'hff) begin
                        $display("Mismatch w_o.strb: expected ff, actual %h", w.strb);
                        tb_errors++;
                    end
                    slave_mem[wa + dcache_pkg::addr_t'(8 * i)] = w.data;
                    i++;
                end
                @(negedge clock);
            end
            w_ready = 1'b0;
            repeat ($urandom_range(3, 0)) @(negedge clock);
            while (stall) @(negedge clock);
            b_valid = 1'b1;
            b       = '{id: dcache_pkg::AXI_ID, resp: 2'b00};
            do @(posedge clock); while (!b_ready);
            @(negedge clock);
            b_valid = 1'b0;
        end
    end

    // AXI read side, one burst at a time
    initial begin : read_slave
        dcache_pkg::addr_t ra;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        forever begin
            do begin
                @(negedge clock);
                ar_ready = rnd_bit();
                @(posedge clock);
            end while (!(ar_valid && ar_ready));
            ra = ar.addr;
            check_burst("ar_o", ar.len, ar.size, ar.burst);
            @(negedge clock);
            ar_ready = 1'b0;
            for (int i = 0; i < dcache_pkg::BEATS_PER_LINE; i++) begin
                while (!rnd_bit()) @(negedge clock);    // random gap
                r_valid = 1'b1;
                r = '{id: dcache_pkg::AXI_ID, data: mem_read(ra + dcache_pkg::addr_t'(8 * i)),
                      resp: 2'b00, last: i == dcache_pkg::BEATS_PER_LINE - 1};
                do @(posedge clock); while (!r_ready);
                @(negedge clock);
                r_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (200 * TOTAL_REQS + 10) @(posedge clock);
        $display("timeout: not all requests completed within %0d cycles", 200 * TOTAL_REQS);
        $display("sim failed");
        $finish;
    end

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input dcache_pkg::line_op_e op, input dcache_pkg::addr_t a,
                            input dcache_pkg::line_t d);
        req_valid = 1'b1;
        req       = '{op: op, addr: a, data: d};
        do @(posedge clock); while (!req_ready);
        @(negedge clock);
        req_valid = 1'b0;
    endtask

    task automatic wait_all_done();
        while (completed != accepted) @(negedge clock);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        if (errs == 0) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    initial begin : main
        int errs0;
        int wb0;
        int acc0;
        int idx;
        dcache_pkg::addr_t a;
        dcache_pkg::line_op_e op;
        void'($urandom(15937));
        reset     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        errs0 = total_errors();
        send_req(dcache_pkg::OP_REFILL, 32'h0000_1000, '0);
        wait_all_done();
        finish_test("single refill", errs0);

        errs0 = total_errors();
        wb0   = wb_seen;
        send_req(dcache_pkg::OP_WRITEBACK, 32'h0000_2000, rand_line());
        send_req(dcache_pkg::OP_REFILL, 32'h0000_2000, '0);    // must wait for B
        wait_all_done();
        if (wb_seen - wb0 != 1) begin
            $display("expected one wb_done_o pulse, saw %0d", wb_seen - wb0);
            tb_errors++;
        end
        finish_test("writeback then refill", errs0);

        errs0     = total_errors();
        ready_pct = 50;
        send_req(dcache_pkg::OP_REFILL, 32'h0000_3000, '0);
        send_req(dcache_pkg::OP_WRITEBACK, 32'h0000_3020, rand_line());
        send_req(dcache_pkg::OP_REFILL, 32'h0000_3020, '0);
        send_req(dcache_pkg::OP_WRITEBACK, 32'h0000_3040, rand_line());
        send_req(dcache_pkg::OP_REFILL, 32'h0000_3040, '0);
        send_req(dcache_pkg::OP_REFILL, 32'h0000_3000, '0);
        wait_all_done();
        finish_test("random slave timing", errs0);

        errs0     = total_errors();
        ready_pct = 100;
        stall     = 1'b1;
        for (int k = 0; k <= QUEUE_DEPTH; k++) begin
            send_req(dcache_pkg::OP_REFILL, 32'h0000_5000 + dcache_pkg::addr_t'(32 * k), '0);
        end
        repeat (3) @(negedge clock);
        if (req_ready) begin
            $display("req_ready_o stayed high with the queue full");
            tb_errors++;
        end
        acc0 = accepted;
        fork
            send_req(dcache_pkg::OP_WRITEBACK, 32'h0000_5100, rand_line());
            begin
                repeat (5) @(negedge clock);
                if (accepted != acc0) begin
                    $display("a request was accepted while the queue was full");
                    tb_errors++;
                end
                stall = 1'b0;
            end
        join
        wait_all_done();
        finish_test("queue full back-pressure", errs0);

        errs0     = total_errors();
        ready_pct = 70;
        for (int i = 0; i < 40; i++) begin
            idx = $urandom_range(7, 0);
            a   = LINE_BASE + dcache_pkg::addr_t'(32 * idx);
            op  = ($urandom_range(1, 0) == 1) ? dcache_pkg::OP_WRITEBACK : dcache_pkg::OP_REFILL;
            // no writeback may overtake an older refill of the same line
            if (op == dcache_pkg::OP_WRITEBACK && open_refills[idx] != 0) begin
                op = dcache_pkg::OP_REFILL;
            end
            send_req(op, a, rand_line());
        end
        wait_all_done();
        finish_test("random mix", errs0);

        repeat (5) @(negedge clock);
        $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, total_errors());
        if (failed == 0 && total_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/dcache_pkg.sv
hdl/miss_queue.sv
hdl/axi_line_master.sv
hdl/refill_assembler.sv
hdl/dcache_axi_top.sv
tests/dcache_assertions.sv
tests/dcache_checker.sv
tests/tb_dcache.sv

//--- Makefile
# Verilator build and run for the data cache bus side

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
